// ==== hw/fpuPkg.sv ====
// Shared constants and types for the binary32 square-root unit
// Class vector is one-hot per operand, the sign is read from the operand
// Flag vector holds only NV and NX, no overflow or underflow bits
`default_nettype none

package fpuPkg;

        // Operand and field widths
        localparam int FpWidth    = 32;
        localparam int ExpWidth   = 10;
        localparam int SigWidth   = 24;
        localparam int SqrtCycles = 26;
        localparam int RootWidth  = 50;

        // Single-precision exponent bias
        localparam logic signed [ExpWidth-1:0] ExpBias = 127;

        // Operand class, one bit per category
        typedef logic [5:0] fpClassT;
        localparam int ClsZero = 0;
        localparam int ClsSub  = 1;
        localparam int ClsNorm = 2;
        localparam int ClsInf  = 3;
        localparam int ClsSnan = 4;
        localparam int ClsQnan = 5;

        // RISC-V frm encodings, codes 5 to 7 are reserved
        typedef enum logic [2:0] {
                RmRne = 3'd0,
                RmRtz = 3'd1,
                RmRdn = 3'd2,
                RmRup = 3'd3,
                RmRmm = 3'd4
        } roundModeT;

        localparam logic [FpWidth-1:0] QNan = 32'h7FC0_0000;

        // Positions in the two-bit flag vector
        localparam int FlagNv = 1;
        localparam int FlagNx = 0;

endpackage

`default_nettype wire

// ==== hw/fpUnpack.sv ====
// Combinational classify and unpack of one binary32 operand
// Subnormals come out normalised with the hidden bit set at sig_o[23]
// Exponent and significand are don't-care for zero, infinity and NaN
`timescale 1ns/1ps
`default_nettype none

module fpUnpack (
        input  wire  [fpuPkg::FpWidth-1:0]              operand_i,
        output fpuPkg::fpClassT                         class_o,
        output logic signed [fpuPkg::ExpWidth-1:0]      exp_o,
        output logic [fpuPkg::SigWidth-1:0]             sig_o
);
        import fpuPkg::*;

        logic [7:0]  expField;
        logic [22:0] fracField;
        logic        expAllZero;
        logic        expAllOnes;
        logic        fracZero;
        logic [4:0]  lz;

        assign expField   = operand_i[30:23];
        assign fracField  = operand_i[22:0];
        assign expAllZero = (expField == 8'h00);
        assign expAllOnes = (expField == 8'hFF);
        assign fracZero   = (fracField == 23'd0);

        // Leading zeros of the fraction
        // Scan upward so the highest set bit has the last word
        always_comb begin
                lz = 5'd0;
                for (int i = 0; i < 23; i++) begin
                        if (fracField[i]) begin
                                lz = 5'(22 - i);
                        end
                end
        end

        always_comb begin
                class_o          = '0;
                class_o[ClsZero] = expAllZero & fracZero;
                class_o[ClsSub]  = expAllZero & ~fracZero;
                class_o[ClsNorm] = ~expAllZero & ~expAllOnes;
                class_o[ClsInf]  = expAllOnes & fracZero;
                // Quiet bit is the fraction MSB
                class_o[ClsSnan] = expAllOnes & ~fracZero & ~fracField[22];
                class_o[ClsQnan] = expAllOnes & fracField[22];
        end

        always_comb begin
                if (expAllZero) begin
                        // Move leading one up to the hidden bit
                        sig_o = {1'b0, fracField} << (lz + 5'd1);
                        // Subnormal scale is 2^-126, minus the shift beyond one
                        exp_o = -ExpBias - $signed(ExpWidth'(lz));
                end else begin
                        sig_o = {1'b1, fracField};
                        exp_o = $signed(ExpWidth'(expField)) - ExpBias;
                end
        end

endmodule

`default_nettype wire

// ==== hw/fpRound.sv ====
// Rounds a wide positive root to a 24-bit significand
// Root MSB must already be the hidden bit, RootWidth at least 26
// Only positive values are handled, so RDN behaves like RTZ
`timescale 1ns/1ps
`default_nettype none

module fpRound #(
        parameter int RootWidth = fpuPkg::RootWidth
) (
        input  wire  [RootWidth-1:0]                    root_i,
        input  wire  signed [fpuPkg::ExpWidth-1:0]      exp_i,
        input  wire  fpuPkg::roundModeT                 rm_i,
        output logic [fpuPkg::SigWidth-1:0]             sig_o,
        output logic signed [fpuPkg::ExpWidth-1:0]      exp_o,
        output logic                                    inexact_o
);
        import fpuPkg::*;

        localparam logic signed [ExpWidth-1:0] ExpOne = 1;

        logic [SigWidth-1:0] sigTrunc;
        logic                guard;
        logic                sticky;
        logic                roundUp;
        logic [SigWidth:0]   sigSum;

        // Kept bits, then guard, then everything below folds into sticky
        assign sigTrunc = root_i[RootWidth-1 -: SigWidth];
        assign guard    = root_i[RootWidth-SigWidth-1];
        assign sticky   = |root_i[RootWidth-SigWidth-2:0];

        always_comb begin
                case (rm_i)
                        // Ties go to even lsb
                        RmRne:   roundUp = guard & (sticky | sigTrunc[0]);
                        // Ties away from zero
                        RmRmm:   roundUp = guard;
                        // Any nonzero tail rounds toward +inf
                        RmRup:   roundUp = guard | sticky;
                        RmRtz:   roundUp = 1'b0;
                        RmRdn:   roundUp = 1'b0;
                        default: roundUp = 1'b0;
                endcase
        end

        assign sigSum = {1'b0, sigTrunc} + (SigWidth+1)'(roundUp);

        // Carry out of all-ones significand
        always_comb begin
                if (sigSum[SigWidth]) begin
                        sig_o = sigSum[SigWidth:1];
                        exp_o = exp_i + ExpOne;
                end else begin
                        sig_o = sigSum[SigWidth-1:0];
                        exp_o = exp_i;
                end
        end

        assign inexact_o = guard | sticky;

endmodule

`default_nettype wire

// ==== hw/fsqrtCore.sv ====
// Iterative binary32 square root, one root bit per cycle
// Special operands finish one cycle after start, others 28 cycles after
// Start is accepted only when idle, later starts are dropped silently
// result_o and flags_o change only in the done cycle
`timescale 1ns/1ps
`default_nettype none

module fsqrtCore (
        input  wire                                     clk_i,
        input  wire                                     rst_i,
        input  wire                                     start_i,
        input  wire  [fpuPkg::FpWidth-1:0]              operand_i,
        input  wire  fpuPkg::fpClassT                   class_i,
        input  wire  signed [fpuPkg::ExpWidth-1:0]      exp_i,
        input  wire  [fpuPkg::SigWidth-1:0]             sig_i,
        input  wire  fpuPkg::roundModeT                 rm_i,
        output fpuPkg::roundModeT                       rmUsed_o,
        output logic [fpuPkg::RootWidth-1:0]            rootWide_o,
        output logic signed [fpuPkg::ExpWidth-1:0]      rootExp_o,
        input  wire  [fpuPkg::SigWidth-1:0]             sigRounded_i,
        input  wire  signed [fpuPkg::ExpWidth-1:0]      expRounded_i,
        input  wire                                     inexact_i,
        output logic                                    busy_o,
        output logic                                    done_o,
        output logic [fpuPkg::FpWidth-1:0]              result_o,
        output logic [1:0]                              flags_o
);
        import fpuPkg::*;

        localparam int CntWidth = $clog2(SqrtCycles);
        // Two radicand bits consumed per root bit
        localparam int RadWidth = 2 * SqrtCycles;
        localparam int RemWidth = SqrtCycles + 2;
        // Low remainder bits passed verbatim below the root
        localparam int LowWidth = RootWidth - SqrtCycles - 1;

        typedef enum logic [2:0] {StIdle, StSpecial, StIter, StLatch, StPack} stateT;

        stateT                      state;
        logic [CntWidth-1:0]        cnt;
        logic [RadWidth-1:0]        rad;
        logic [RemWidth-1:0]        rem;
        logic [SqrtCycles-1:0]      root;
        logic [FpWidth-1:0]         specResult;
        logic                       specNv;
        logic                       passThrough;
        logic                       invalidOp;
        logic                       accept;
        logic [RemWidth+1:0]        remShift;
        logic [RemWidth+1:0]        trial;
        logic [RemWidth+2:0]        diff;
        logic                       rootBit;
        logic [RemWidth-1:0]        remNext;
        logic signed [ExpWidth-1:0] packExp;
        logic [1:0]                 specFlagVec;
        logic [1:0]                 packFlagVec;

        assign accept = (state == StIdle) & start_i;
        assign busy_o = (state != StIdle);

        // Zero and qNaN keep the operand, +inf returns itself
        assign passThrough = class_i[ClsZero] | class_i[ClsQnan]
                           | (class_i[ClsInf] & ~operand_i[FpWidth-1]);
        // sNaN of either sign, or any negative nonzero non-NaN
        assign invalidOp = class_i[ClsSnan]
                         | (operand_i[FpWidth-1] & ~class_i[ClsZero] & ~class_i[ClsQnan]);

        // One restoring step, trial is 4*root + 1
        always_comb begin
                remShift = {rem, rad[RadWidth-1 -: 2]};
                trial    = {{(RemWidth-SqrtCycles){1'b0}}, root, 2'b01};
                diff     = {1'b0, remShift} - {1'b0, trial};
                rootBit  = ~diff[RemWidth+2];
                remNext  = rootBit ? diff[RemWidth-1:0] : remShift[RemWidth-1:0];
        end

        assign packExp = expRounded_i + ExpBias;

        always_comb begin
                specFlagVec         = '0;
                specFlagVec[FlagNv] = specNv;
                packFlagVec         = '0;
                packFlagVec[FlagNx] = inexact_i;
        end

        // Sequencer
        always_ff @(posedge clk_i) begin
                if (rst_i) begin
                        state  <= StIdle;
                        cnt    <= '0;
                        done_o <= 1'b0;
                end else begin
                        done_o <= 1'b0;
                        case (state)
                                StIdle: begin
                                        if (start_i) begin
                                                state <= (passThrough | invalidOp) ? StSpecial
                                                                                   : StIter;
                                                cnt   <= CntWidth'(SqrtCycles - 1);
                                        end
                                end
                                StSpecial: begin
                                        state  <= StIdle;
                                        done_o <= 1'b1;
                                end
                                StIter: begin
                                        // Last step runs with cnt at zero
                                        if (cnt == '0) begin
                                                state <= StLatch;
                                        end else begin
                                                cnt <= cnt - 1'b1;
                                        end
                                end
                                StLatch: state <= StPack;
                                StPack: begin
                                        state  <= StIdle;
                                        done_o <= 1'b1;
                                end
                                default: state <= StIdle;
                        endcase
                end
        end

        // Datapath
        always_ff @(posedge clk_i) begin
                if (accept) begin
                        rmUsed_o   <= rm_i;
                        // Floor halving, odd exponent folds into the radicand
                        rootExp_o  <= exp_i >>> 1;
                        rad        <= exp_i[0] ? {sig_i, {(RadWidth-SigWidth){1'b0}}}
                                               : {1'b0, sig_i, {(RadWidth-SigWidth-1){1'b0}}};
                        rem        <= '0;
                        root       <= '0;
                        specResult <= invalidOp ? QNan : operand_i;
                        specNv     <= invalidOp;
                end
                if (state == StIter) begin
                        rad  <= rad << 2;
                        rem  <= remNext;
                        root <= {root[SqrtCycles-2:0], rootBit};
                end
                // Root MSB is always set here, upper remainder bits only feed sticky
                if (state == StLatch) begin
                        rootWide_o <= {root, |rem[RemWidth-1:LowWidth], rem[LowWidth-1:0]};
                end
                if (state == StSpecial) begin
                        result_o <= specResult;
                        flags_o  <= specFlagVec;
                end
                if (state == StPack) begin
                        result_o <= {1'b0, packExp[7:0], sigRounded_i[SigWidth-2:0]};
                        flags_o  <= packFlagVec;
                end
        end

endmodule

`default_nettype wire

// ==== hw/fpCsr.sv ====
// Dynamic rounding mode and accrued exception flags
// Reserved frm codes are stored as RNE
// A write clears the flags and beats a same-cycle done
`timescale 1ns/1ps
`default_nettype none

module fpCsr (
        input  wire                             clk_i,
        input  wire                             rst_i,
        input  wire                             csrWe_i,
        input  wire  fpuPkg::roundModeT         csrFrm_i,
        input  wire                             done_i,
        input  wire  [1:0]                      flags_i,
        output fpuPkg::roundModeT               frm_o,
        output logic [1:0]                      fflags_o
);
        import fpuPkg::*;

        logic legalFrm;

        // Codes above RMM are reserved
        assign legalFrm = (csrFrm_i <= RmRmm);

        always_ff @(posedge clk_i) begin
                if (rst_i) begin
                        frm_o    <= RmRne;
                        fflags_o <= '0;
                end else if (csrWe_i) begin
                        frm_o    <= legalFrm ? csrFrm_i : RmRne;
                        fflags_o <= '0;
                end else if (done_i) begin
                        // Sticky accumulation per operation
                        fflags_o <= fflags_o | flags_i;
                end
        end

endmodule

`default_nettype wire

// ==== hw/fsqrtTop.sv ====
// Square-root unit top level, CSR block beside the core
// No back-pressure, caller waits for done_o before the next start
`timescale 1ns/1ps
`default_nettype none

module fsqrtTop (
        input  wire                             clk_i,
        input  wire                             rst_i,
        input  wire                             start_i,
        input  wire  [fpuPkg::FpWidth-1:0]      operand_i,
        input  wire                             csrWe_i,
        input  wire  fpuPkg::roundModeT         csrFrm_i,
        output logic                            busy_o,
        output logic                            done_o,
        output logic [fpuPkg::FpWidth-1:0]      result_o,
        output logic [1:0]                      flags_o,
        output logic [1:0]                      fflags_o,
        output fpuPkg::roundModeT               frm_o
);
        import fpuPkg::*;

        fpClassT                    opClass;
        logic signed [ExpWidth-1:0] opExp;
        logic [SigWidth-1:0]        opSig;
        roundModeT                  rmUsed;
        logic [RootWidth-1:0]       rootWide;
        logic signed [ExpWidth-1:0] rootExp;
        logic [SigWidth-1:0]        sigRounded;
        logic signed [ExpWidth-1:0] expRounded;
        logic                       inexact;

        fpCsr i_csr (
                .clk_i(clk_i), .rst_i(rst_i), .csrWe_i(csrWe_i), .csrFrm_i(csrFrm_i),
                .done_i(done_o), .flags_i(flags_o), .frm_o(frm_o), .fflags_o(fflags_o)
        );

        fpUnpack i_unpack (.operand_i(operand_i), .class_o(opClass), .exp_o(opExp), .sig_o(opSig));

        fsqrtCore i_core (
                .clk_i(clk_i), .rst_i(rst_i), .start_i(start_i), .operand_i(operand_i),
                .class_i(opClass), .exp_i(opExp), .sig_i(opSig), .rm_i(frm_o),
                .rmUsed_o(rmUsed), .rootWide_o(rootWide), .rootExp_o(rootExp),
                .sigRounded_i(sigRounded), .expRounded_i(expRounded), .inexact_i(inexact),
                .busy_o(busy_o), .done_o(done_o), .result_o(result_o), .flags_o(flags_o)
        );

        // Rounding uses the mode captured at start
        fpRound #(.RootWidth(RootWidth)) i_round (
                .root_i(rootWide), .exp_i(rootExp), .rm_i(rmUsed),
                .sig_o(sigRounded), .exp_o(expRounded), .inexact_o(inexact)
        );

endmodule

`default_nettype wire

// ==== verification/fsqrtCore_props.sv ====
// Handshake and counter assertions for the square-root core
// Counter width must match the core's own iteration counter
`timescale 1ns/1ps
`default_nettype none

module fsqrtCoreProps #(
        parameter int CntWidth = $clog2(fpuPkg::SqrtCycles)
) (
        input wire                      clk_i,
        input wire                      rst_i,
        input wire                      start_i,
        input wire                      busy_i,
        input wire                      done_i,
        input wire      [CntWidth-1:0]  cnt_i
);
        // Done is a single-cycle pulse
        assert property (@(posedge clk_i) disable iff (rst_i) done_i |=> !done_i)
                else $error("done_o high in two consecutive cycles");

        // Done only ends an operation that was running
        assert property (@(posedge clk_i) disable iff (rst_i)
                done_i |-> ($past(busy_i) || $past(start_i, 2)))
                else $error("done_o without a preceding busy cycle or start");

        // A start while busy never reloads the counter
        assert property (@(posedge clk_i) disable iff (rst_i)
                (start_i && busy_i) |=>
                (cnt_i == $past(cnt_i) || cnt_i == CntWidth'($past(cnt_i) - 1'b1)))
                else $error("counter disturbed by a start while busy");

endmodule

bind fsqrtCore fsqrtCoreProps i_props (
        .clk_i(clk_i), .rst_i(rst_i), .start_i(start_i),
        .busy_i(busy_o), .done_i(done_o), .cnt_i(cnt)
);

`default_nettype wire

// ==== verification/fsqrtTb.sv ====
// Directed testbench for the binary32 square-root unit
// Expected values are hand-worked IEEE-754 results, one table row per operation
// Each wait for done_o gives up after 100 cycles
`timescale 1ns/1ps
`default_nettype none

module fsqrtTb;
        import fpuPkg::*;

        localparam int TimeoutCycles = 100;
        // Flag vector is {NV, NX}
        localparam logic [1:0] NoFlags = 2'b00;
        localparam logic [1:0] NvOnly  = 2'b10;
        localparam logic [1:0] NxOnly  = 2'b01;

        typedef struct packed {
                logic [31:0] operand;
                logic [2:0]  rm;
                logic [31:0] result;
                logic [1:0]  flags;
                logic [5:0]  latency;
        } rowT;

        logic        clk;
        logic        rst;
        logic        start;
        logic [31:0] operand;
        logic        csrWe;
        roundModeT   csrFrm;
        logic        busy;
        logic        done;
        logic [31:0] result;
        logic [1:0]  flags;
        logic [1:0]  fflags;
        roundModeT   frm;

        rowT rows[$];
        int  errors;
        int  checks;
        bit  timedOut;

        fsqrtTop i_dut (
                .clk_i(clk), .rst_i(rst), .start_i(start), .operand_i(operand),
                .csrWe_i(csrWe), .csrFrm_i(csrFrm), .busy_o(busy), .done_o(done),
                .result_o(result), .flags_o(flags), .fflags_o(fflags), .frm_o(frm)
        );

        initial begin
                clk = 1'b0;
                forever #4 clk = ~clk;
        end

        task automatic checkValue(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
                checks++;
                if (actual !== expected) begin
                        errors++;
                        $display("[FAIL] t=%0t %s expected %h got %h", $time, name, expected,
                                 actual);
                end
        endtask

        task automatic addRow(input logic [31:0] op, input logic [2:0] rm,
                              input logic [31:0] res, input logic [1:0] flg,
                              input logic [5:0] lat);
                rowT row;
                row.operand = op;
                row.rm      = rm;
                row.result  = res;
                row.flags   = flg;
                row.latency = lat;
                rows.push_back(row);
        endtask

        // Write frm, which also clears the accrued flags
        task automatic writeCsr(input logic [2:0] code);
                logic [2:0] expFrm;
                // Reserved codes 5 to 7 read back as RNE
                expFrm = (code > 3'd4) ? 3'd0 : code;
                @(posedge clk);
                csrWe  <= 1'b1;
                csrFrm <= roundModeT'(code);
                @(posedge clk);
                csrWe  <= 1'b0;
                @(negedge clk);
                checkValue("frm_o", 32'(expFrm), 32'(frm));
                checkValue("fflags_o", 32'(NoFlags), 32'(fflags));
        endtask

        task automatic startPulse(input logic [31:0] op);
                @(posedge clk);
                operand <= op;
                start   <= 1'b1;
                @(posedge clk);
                start   <= 1'b0;
        endtask

        // Cycles counted from the edge that samples start
        task automatic waitDone(output int lat);
                lat = 0;
                while (!timedOut) begin
                        @(posedge clk);
                        lat++;
                        @(negedge clk);
                        if (done) begin
                                break;
                        end
                        checkValue("busy_o", 32'd1, 32'(busy));
                        if (lat >= TimeoutCycles) begin
                                timedOut = 1'b1;
                                errors++;
                                $display("Timed out after %0d cycles waiting for done_o", lat);
                        end
                end
        endtask

        task automatic runRow(input rowT r);
                int lat;
                writeCsr(r.rm);
                startPulse(r.operand);
                waitDone(lat);
                if (!timedOut) begin
                        checkValue("result_o", r.result, result);
                        checkValue("flags_o", 32'(r.flags), 32'(flags));
                        checkValue("latency", 32'(r.latency), 32'(lat));
                        @(negedge clk);
                        checkValue("fflags_o", 32'(r.flags), 32'(fflags));
                end
        endtask

        task automatic loadTable();
                // Exact roots
                addRow(32'h4080_0000, 3'd0, 32'h4000_0000, NoFlags, 6'd28);
                addRow(32'h3F80_0000, 3'd0, 32'h3F80_0000, NoFlags, 6'd28);
                addRow(32'h3E80_0000, 3'd0, 32'h3F00_0000, NoFlags, 6'd28);
                addRow(32'h4010_0000, 3'd0, 32'h3FC0_0000, NoFlags, 6'd28);
                // sqrt(2) lies just above 0x3FB504F3, far from the halfway point
                addRow(32'h4000_0000, 3'd0, 32'h3FB5_04F3, NxOnly, 6'd28);
                addRow(32'h4000_0000, 3'd1, 32'h3FB5_04F3, NxOnly, 6'd28);
                addRow(32'h4000_0000, 3'd2, 32'h3FB5_04F3, NxOnly, 6'd28);
                addRow(32'h4000_0000, 3'd3, 32'h3FB5_04F4, NxOnly, 6'd28);
                addRow(32'h4000_0000, 3'd4, 32'h3FB5_04F3, NxOnly, 6'd28);
                // Odd exponents, positive and negative
                addRow(32'h4100_0000, 3'd0, 32'h4035_04F3, NxOnly, 6'd28);
                addRow(32'h4100_0000, 3'd3, 32'h4035_04F4, NxOnly, 6'd28);
                addRow(32'h3F00_0000, 3'd0, 32'h3F35_04F3, NxOnly, 6'd28);
                // Subnormal 2^-140 gives 2^-70
                addRow(32'h0000_0200, 3'd0, 32'h1C80_0000, NoFlags, 6'd28);
                // Special operands
                addRow(32'h0000_0000, 3'd0, 32'h0000_0000, NoFlags, 6'd1);
                addRow(32'h8000_0000, 3'd0, 32'h8000_0000, NoFlags, 6'd1);
                addRow(32'h7F80_0000, 3'd0, 32'h7F80_0000, NoFlags, 6'd1);
                addRow(32'h7FC0_0001, 3'd0, 32'h7FC0_0001, NoFlags, 6'd1);
                addRow(32'hC080_0000, 3'd0, 32'h7FC0_0000, NvOnly, 6'd1);
                addRow(32'h7F80_0001, 3'd0, 32'h7FC0_0000, NvOnly, 6'd1);
                addRow(32'hFF80_0000, 3'd0, 32'h7FC0_0000, NvOnly, 6'd1);
        endtask

        // Flags accumulate across operations until a CSR write
        task automatic csrCheck();
                int lat;
                writeCsr(3'd0);
                startPulse(32'hC080_0000);
                waitDone(lat);
                startPulse(32'h4000_0000);
                waitDone(lat);
                @(negedge clk);
                checkValue("fflags_o", 32'(NvOnly | NxOnly), 32'(fflags));
                // Each reserved code follows a legal mode other than RNE
                writeCsr(3'd3);
                writeCsr(3'd5);
                writeCsr(3'd4);
                writeCsr(3'd7);
        endtask

        // Second start mid-operation must be dropped
        task automatic busyCheck();
                int lat;
                int extra;
                extra = 0;
                writeCsr(3'd0);
                startPulse(32'h4080_0000);
                repeat (4) @(posedge clk);
                startPulse(32'h4110_0000);
                waitDone(lat);
                if (!timedOut) begin
                        checkValue("result_o", 32'h4000_0000, result);
                        for (int i = 0; i < 40; i++) begin
                                @(negedge clk);
                                if (done) begin
                                        extra++;
                                end
                        end
                        if (extra != 0) begin
                                errors++;
                                $display("A start while busy produced %0d extra done pulses",
                                         extra);
                        end
                end
        endtask

        initial begin
                rst      = 1'b1;
                start    = 1'b0;
                operand  = '0;
                csrWe    = 1'b0;
                csrFrm   = RmRne;
                errors   = 0;
                checks   = 0;
                timedOut = 1'b0;
                repeat (8) @(posedge clk);
                rst <= 1'b0;
                @(negedge clk);
                checkValue("done_o", 32'd0, 32'(done));
                checkValue("busy_o", 32'd0, 32'(busy));
                checkValue("frm_o", 32'd0, 32'(frm));
                checkValue("fflags_o", 32'd0, 32'(fflags));
                loadTable();
                foreach (rows[i]) begin
                        if (!timedOut) begin
                                runRow(rows[i]);
                        end
                end
                if (!timedOut) begin
                        csrCheck();
                end
                if (!timedOut) begin
                        busyCheck();
                end
                $display("Checks run: %0d, errors: %0d", checks, errors);
                if (errors == 0) begin
                        $display("Testbench passed");
                end else begin
                        $display("Testbench failed");
                end
                $finish;
        end

endmodule

`default_nettype wire

// ==== sources.f ====
hw/fpuPkg.sv
hw/fpUnpack.sv
hw/fpRound.sv
hw/fsqrtCore.sv
hw/fpCsr.sv
hw/fsqrtTop.sv
verification/fsqrtCore_props.sv
verification/fsqrtTb.sv

// ==== Makefile ====
# Verilator build and run of the square-root unit testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= fsqrtTb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Testbench passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "Result: pass"; \
	else \
		echo "Result: fail, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
